/* src.f */
+incdir+src
src/hop_tx_pkg.sv
src/hop_config.sv
src/hop_sequencer.sv
src/scan_loader.sv
src/tone_nco.sv
src/gpio_pin_map.sv
src/hop_tx_top.sv
verif/hop_tx_sva.sv
verif/hop_tx_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module hop_tx_tb -Mdir obj_dir

sim_out=$(./obj_dir/Vhop_tx_tb +verilator+error+limit+1000)
echo "$sim_out"

if grep -qx -- '=== PASS ===' <<< "$sim_out"; then
  exit 0
fi
exit 1

/* verif/hop_tx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module hop_tx_tb;

  import hop_tx_pkg::*;

  logic               clk;
  logic               reset;
  logic               cfg_we;
  logic [3:0]         cfg_addr;
  logic [15:0]        cfg_wdata;
  logic [`GPIO_W-1:0] gpio_in;
  logic [`GPIO_W-1:0] gpio_out;
  logic [`GPIO_W-1:0] gpio_ddr;
  sample_t            itx;
  sample_t            qtx;
  logic               busy;
  hop_idx_t           hop_idx;

  logic [31:0] lfsr_q;
  int          errors;
  int          timeouts;
  int          cfg_hops;
  int          cfg_sync;
  phase_t      cfg_base;
  phase_t      cfg_step;
  hop_code_t   codes [`MAX_HOPS];

  logic        sync_prev;
  logic        tx_prev;
  logic        phi_prev;
  logic        load_prev;
  logic        busy_prev;
  int          hops;
  int          sync_cnt;
  int          nbits;
  int          loads;
  hop_code_t   bits;
  phase_t      m_phase;
  phase_t      cur_inc;

  hop_tx_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .gpio_ddr  (gpio_ddr),
    .itx       (itx),
    .qtx       (qtx),
    .busy      (busy),
    .hop_idx   (hop_idx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  function automatic int ref_sample(logic [3:0] k, bit cosine);
    real ang;
    real v;
    ang = 3.14159265358979 * k / 8.0;
    v = cosine ? 2047.0 * $cos(ang) : 2047.0 * $sin(ang);
    return (v < 0.0) ? -$rtoi(0.5 - v) : $rtoi(v + 0.5);
  endfunction

  task automatic report_mismatch(string msg);
    errors++;
    $display("MISMATCH at %0d ns: %s", $time, msg);
  endtask

  task automatic write_reg(logic [3:0] addr, logic [15:0] data);
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic wait_busy(logic level, int limit);
    int n;
    n = 0;
    while (busy !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy !== level) begin
      timeouts++;
      $display("timeout: busy did not go to %0b within %0d cycles", level, limit);
    end
  endtask

  // m_phase holds the phase that the current sample was taken from.
  task automatic check_sample();
    int exp_i;
    int exp_q;
    exp_i = ref_sample(m_phase[`PHASE_W-1 -: 4], 1'b1);
    exp_q = ref_sample(m_phase[`PHASE_W-1 -: 4], 1'b0);
    assert (int'(itx) == exp_i && int'(qtx) == exp_q)
      else report_mismatch($sformatf("hop %0d sample I=%0d Q=%0d, expected I=%0d Q=%0d",
                                     hops - 1, itx, qtx, exp_i, exp_q));
    m_phase = m_phase + cur_inc;
  endtask

  // pins and samples both lag the sequencer state by one register.
  always @(negedge clk) begin
    if (reset) begin
      sync_prev = 1'b0;
      tx_prev = 1'b0;
      phi_prev = 1'b0;
      load_prev = 1'b0;
      busy_prev = 1'b0;
      hops = 0;
      sync_cnt = 0;
      m_phase = '0;
      cur_inc = '0;
    end else begin
      if (busy && !busy_prev) begin
        hops = 0;
      end
      if (!busy && busy_prev) begin
        assert (hops == cfg_hops)
          else report_mismatch($sformatf("%0d hops in run, expected %0d", hops, cfg_hops));
      end
      if (gpio_out[`PIN_SYNC] && !sync_prev) begin
        assert (hop_idx == hop_idx_t'(hops))
          else report_mismatch($sformatf("hop_idx %0d, expected %0d", hop_idx, hops));
        cur_inc = cfg_base + phase_t'(hops * cfg_step);
        sync_cnt = 0;
        hops++;
      end
      if (!gpio_out[`PIN_SYNC] && sync_prev) begin
        assert (sync_cnt == cfg_sync)
          else report_mismatch($sformatf("sync pin high %0d cycles, expected %0d",
                                         sync_cnt, cfg_sync));
      end
      if (gpio_out[`PIN_TX] && !tx_prev) begin
        nbits = 0;
        bits = '0;
        loads = 0;
      end
      if (gpio_out[`PIN_TX] && gpio_out[`PIN_PHI] && !phi_prev) begin
        bits = {bits[`HOP_CODE_W-2:0], gpio_out[`PIN_DATA]};
        nbits++;
      end
      if (gpio_out[`PIN_TX] && gpio_out[`PIN_LOAD] && !load_prev) begin
        loads++;
        assert (nbits == `HOP_CODE_W && bits == codes[hops-1])
          else report_mismatch($sformatf("hop %0d scanned %0d bits %h, expected 8 bits %h",
                                         hops - 1, nbits, bits, codes[hops-1]));
      end
      if (!gpio_out[`PIN_TX] && tx_prev) begin
        assert (loads == 1)
          else report_mismatch($sformatf("%0d load pulses in hop, expected 1", loads));
      end
      if (gpio_out[`PIN_SYNC] && sync_cnt < cfg_sync / 4) begin
        assert (itx == 0 && qtx == 0)
          else report_mismatch($sformatf("tone not muted %0d cycles into sync", sync_cnt));
        m_phase = '0;
      end else if (gpio_out[`PIN_SYNC] || gpio_out[`PIN_TX]) begin
        check_sample();
      end
      if (gpio_out[`PIN_SYNC]) begin
        sync_cnt++;
      end
      sync_prev = gpio_out[`PIN_SYNC];
      tx_prev = gpio_out[`PIN_TX];
      phi_prev = gpio_out[`PIN_PHI];
      load_prev = gpio_out[`PIN_LOAD];
      busy_prev = busy;
    end
  end

  initial begin
    reset = 1'b1;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    gpio_in = '0;
    lfsr_q = 32'h75ea_a951;
    errors = 0;
    timeouts = 0;
    cfg_hops = 1;
    cfg_sync = 64;
    cfg_base = '0;
    cfg_step = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (gpio_out == '0 && itx == 0 && qtx == 0 && !busy && gpio_ddr == `GPIO_DDR_MASK)
      else report_mismatch("outputs not at their reset values");
    for (int run = 0; run < 2; run++) begin
      repeat (20) begin
        @(negedge clk);
        assert (!busy) else report_mismatch("busy high while the enable pin is low");
      end
      cfg_hops = 1 + rand_bits(3);
      cfg_sync = 16 + rand_bits(6) % 49;
      cfg_base = phase_t'(rand_bits(16));
      cfg_step = phase_t'(rand_bits(16));
      write_reg(4'd0, 16'(cfg_hops));
      write_reg(4'd1, 16'(cfg_sync));
      write_reg(4'd2, cfg_base);
      write_reg(4'd3, cfg_step);
      for (int i = 0; i < `MAX_HOPS; i++) begin
        codes[i] = hop_code_t'(rand_bits(8));
        write_reg(4'(8 + i), 16'(codes[i]));
      end
      gpio_in[`PIN_EN_IN] = 1'b1;
      wait_busy(1'b1, 20);
      gpio_in[`PIN_EN_IN] = 1'b0;
      wait_busy(1'b0, 5000);
    end
    repeat (4) @(negedge clk);
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             errors, timeouts, i_dut.i_sva.fail_count);
    if (errors + timeouts + i_dut.i_sva.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/hop_tx_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module hop_tx_sva (
  input logic               clk,
  input logic               reset,
  input logic [`GPIO_W-1:0] gpio_out,
  input logic               scan_done
);

  int fail_count = 0;

  // the two scan clocks must never overlap on the pins.
  phi_excl: assert property (@(posedge clk) disable iff (reset)
      !(gpio_out[`PIN_PHI] && gpio_out[`PIN_PHI_BAR]))
    else begin
      fail_count++;
      $error("phi and phi_bar are high together");
    end

  done_pulse: assert property (@(posedge clk) disable iff (reset)
      scan_done |=> !scan_done)
    else begin
      fail_count++;
      $error("scan_done is longer than one cycle");
    end

  // a hop is either in its sync period or transmitting.
  sync_tx_excl: assert property (@(posedge clk) disable iff (reset)
      !(gpio_out[`PIN_SYNC] && gpio_out[`PIN_TX]))
    else begin
      fail_count++;
      $error("sync and tx pins are high together");
    end

  load_alone: assert property (@(posedge clk) disable iff (reset)
      gpio_out[`PIN_LOAD] |-> !gpio_out[`PIN_SCAN_ID] && !gpio_out[`PIN_PHI])
    else begin
      fail_count++;
      $error("load pin overlaps the scan bits");
    end

endmodule

bind hop_tx_top hop_tx_sva i_sva (
  .clk       (clk),
  .reset     (reset),
  .gpio_out  (gpio_out),
  .scan_done (scan_done)
);

`default_nettype wire

/* src/hop_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module hop_tx_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cfg_we,
  input  logic [3:0]           cfg_addr,
  input  logic [15:0]          cfg_wdata,
  input  logic [`GPIO_W-1:0]   gpio_in,
  output logic [`GPIO_W-1:0]   gpio_out,
  output logic [`GPIO_W-1:0]   gpio_ddr,
  output hop_tx_pkg::sample_t  itx,
  output hop_tx_pkg::sample_t  qtx,
  output logic                 busy,
  output hop_tx_pkg::hop_idx_t hop_idx
);

  import hop_tx_pkg::*;

  hop_cfg_t   cfg;
  hop_code_t  code;
  phase_t     phase_inc;
  scan_pins_t pins;
  logic       scan_start;
  logic       scan_done;
  logic       sync_active;
  logic       mute;
  logic       tx_active;
  logic       tx_en;

  hop_config i_config (
    .clk       (clk),
    .reset     (reset),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .hop_idx   (hop_idx),
    .cfg       (cfg),
    .code      (code)
  );

  hop_sequencer i_sequencer (
    .clk         (clk),
    .reset       (reset),
    .tx_en       (tx_en),
    .cfg         (cfg),
    .scan_done   (scan_done),
    .scan_start  (scan_start),
    .sync_active (sync_active),
    .mute        (mute),
    .tx_active   (tx_active),
    .busy        (busy),
    .hop_idx     (hop_idx),
    .phase_inc   (phase_inc)
  );

  scan_loader i_scan (
    .clk   (clk),
    .reset (reset),
    .start (scan_start),
    .code  (code),
    .pins  (pins),
    .done  (scan_done)
  );

  tone_nco i_nco (
    .clk       (clk),
    .reset     (reset),
    .mute      (mute),
    .phase_inc (phase_inc),
    .itx       (itx),
    .qtx       (qtx)
  );

  gpio_pin_map i_gpio (
    .clk         (clk),
    .reset       (reset),
    .pins        (pins),
    .sync_active (sync_active),
    .tx_active   (tx_active),
    .gpio_in     (gpio_in),
    .gpio_out    (gpio_out),
    .gpio_ddr    (gpio_ddr),
    .tx_en       (tx_en)
  );

endmodule

`default_nettype wire

/* src/gpio_pin_map.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module gpio_pin_map (
  input  logic                   clk,
  input  logic                   reset,
  input  hop_tx_pkg::scan_pins_t pins,
  input  logic                   sync_active,
  input  logic                   tx_active,
  input  logic [`GPIO_W-1:0]     gpio_in,
  output logic [`GPIO_W-1:0]     gpio_out,
  output logic [`GPIO_W-1:0]     gpio_ddr,
  output logic                   tx_en
);

  logic [`GPIO_W-1:0] out_d;
  logic               en_meta;

  always_comb begin
    out_d                = '0;
    out_d[`PIN_SYNC]     = sync_active;
    out_d[`PIN_LOAD]     = pins.load;
    out_d[`PIN_DATA]     = pins.data;
    out_d[`PIN_PHI_BAR]  = pins.phi_bar;
    out_d[`PIN_PHI]      = pins.phi;
    out_d[`PIN_SCAN_ID]  = pins.scan_id;
    out_d[`PIN_TX]       = tx_active;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_out <= '0;
      en_meta  <= 1'b0;
      tx_en    <= 1'b0;
    end else begin
      gpio_out <= out_d;
      // the enable pin is asynchronous to clk.
      en_meta  <= gpio_in[`PIN_EN_IN];
      tx_en    <= en_meta;
    end
  end

  always_ff @(posedge clk) begin
    gpio_ddr <= `GPIO_DDR_MASK;
  end

endmodule

`default_nettype wire

/* src/tone_nco.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module tone_nco (
  input  logic                clk,
  input  logic                reset,
  input  logic                mute,
  input  hop_tx_pkg::phase_t  phase_inc,
  output hop_tx_pkg::sample_t itx,
  output hop_tx_pkg::sample_t qtx
);

  import hop_tx_pkg::*;

  // round(2047 * sin(2*pi*k/16)).
  localparam sample_t SINE_LUT [16] = '{
    12'sd0,     12'sd783,   12'sd1447,  12'sd1891,
    12'sd2047,  12'sd1891,  12'sd1447,  12'sd783,
    12'sd0,    -12'sd783,  -12'sd1447, -12'sd1891,
    -12'sd2047, -12'sd1891, -12'sd1447, -12'sd783
  };

  phase_t     phase;
  logic [3:0] sin_idx;
  logic [3:0] cos_idx;

  assign sin_idx = phase[`PHASE_W-1 -: 4];
  assign cos_idx = sin_idx + 4'd4;

  always_ff @(posedge clk) begin
    if (reset || mute) begin
      phase <= '0;
    end else begin
      phase <= phase + phase_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || mute) begin
      itx <= '0;
      qtx <= '0;
    end else begin
      itx <= SINE_LUT[cos_idx];
      qtx <= SINE_LUT[sin_idx];
    end
  end

endmodule

`default_nettype wire

/* src/scan_loader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module scan_loader (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  hop_tx_pkg::hop_code_t  code,
  output hop_tx_pkg::scan_pins_t pins,
  output logic                   done
);

  import hop_tx_pkg::*;

  localparam int DIV_W = $clog2(`SCAN_DIV);
  localparam int BIT_W = $clog2(`HOP_CODE_W) + 1;

  logic             active;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [1:0]       ph_cnt;
  hop_code_t        shreg;
  logic             tick;
  logic             in_bits;
  logic             load_step;

  assign tick      = active && (div_cnt == DIV_W'(`SCAN_DIV - 1));
  assign load_step = (bit_cnt == BIT_W'(`HOP_CODE_W));
  assign in_bits   = active && !load_step;

  always_ff @(posedge clk) begin
    if (reset) begin
      active  <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      ph_cnt  <= '0;
    end else if (!active) begin
      if (start) begin
        active  <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
        ph_cnt  <= '0;
      end
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
      if (tick) begin
        if (load_step) begin
          active <= 1'b0;
        end else if (ph_cnt == 2'd2) begin
          ph_cnt  <= '0;
          bit_cnt <= bit_cnt + BIT_W'(1);
        end else begin
          ph_cnt <= ph_cnt + 2'd1;
        end
      end
    end
  end

  // the code is shifted out MSB first, one bit after each phi_bar step.
  always_ff @(posedge clk) begin
    if (!active && start) begin
      shreg <= code;
    end else if (tick && in_bits && ph_cnt == 2'd2) begin
      shreg <= {shreg[`HOP_CODE_W-2:0], 1'b0};
    end
  end

  assign pins.scan_id = in_bits;
  assign pins.data    = in_bits && shreg[`HOP_CODE_W-1];
  assign pins.phi     = in_bits && (ph_cnt == 2'd1);
  assign pins.phi_bar = in_bits && (ph_cnt == 2'd2);
  assign pins.load    = active && load_step;

  assign done = tick && load_step;

endmodule

`default_nettype wire

/* src/hop_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module hop_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tx_en,
  input  hop_tx_pkg::hop_cfg_t cfg,
  input  logic                 scan_done,
  output logic                 scan_start,
  output logic                 sync_active,
  output logic                 mute,
  output logic                 tx_active,
  output logic                 busy,
  output hop_tx_pkg::hop_idx_t hop_idx,
  output hop_tx_pkg::phase_t   phase_inc
);

  import hop_tx_pkg::*;

  seq_state_t state;
  count_t     sync_cnt;
  logic       sync_last;
  logic       more_hops;

  assign sync_last = (sync_cnt == cfg.sync_len - count_t'(1));
  assign more_hops = (hop_num_t'(hop_idx) + hop_num_t'(1)) < cfg.num_hops;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= INIT;
      sync_cnt   <= '0;
      hop_idx    <= '0;
      phase_inc  <= '0;
      scan_start <= 1'b0;
    end else begin
      scan_start <= 1'b0;
      case (state)
        INIT: begin
          if (tx_en) begin
            state     <= LOC_SYNC;
            sync_cnt  <= '0;
            hop_idx   <= '0;
            phase_inc <= cfg.base_inc;
          end
        end
        LOC_SYNC: begin
          if (sync_last) begin
            state    <= HOP_SYNC;
            sync_cnt <= '0;
          end else begin
            sync_cnt <= sync_cnt + count_t'(1);
          end
        end
        HOP_SYNC: begin
          if (sync_last) begin
            // scan_start is high in the first HOP_TX cycle.
            state      <= HOP_TX;
            sync_cnt   <= '0;
            scan_start <= 1'b1;
          end else begin
            sync_cnt <= sync_cnt + count_t'(1);
          end
        end
        HOP_TX: begin
          if (scan_done) begin
            if (more_hops) begin
              state     <= HOP_SYNC;
              hop_idx   <= hop_idx + hop_idx_t'(1);
              phase_inc <= phase_inc + cfg.hop_step;
            end else begin
              state <= INIT;
            end
          end
        end
        default: state <= INIT;
      endcase
    end
  end

  assign sync_active = (state == HOP_SYNC);
  assign tx_active   = (state == HOP_TX);
  assign busy        = (state != INIT);

  // the tone is silent while idle and over the first quarter of each hop sync.
  assign mute = (state == INIT) ||
                (sync_active && (sync_cnt < (cfg.sync_len >> 2)));

endmodule

`default_nettype wire

/* src/hop_config.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hop_tx_params.svh"

module hop_config (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cfg_we,
  input  logic [3:0]            cfg_addr,
  input  logic [15:0]           cfg_wdata,
  input  hop_tx_pkg::hop_idx_t  hop_idx,
  output hop_tx_pkg::hop_cfg_t  cfg,
  output hop_tx_pkg::hop_code_t code
);

  import hop_tx_pkg::*;

  hop_code_t code_tbl [`MAX_HOPS];

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.num_hops <= hop_num_t'(1);
      cfg.sync_len <= count_t'(64);
      cfg.base_inc <= '0;
      cfg.hop_step <= '0;
      for (int i = 0; i < `MAX_HOPS; i++) begin
        code_tbl[i] <= '0;
      end
    end else if (cfg_we) begin
      if (cfg_addr[3]) begin
        code_tbl[cfg_addr[2:0]] <= cfg_wdata[`HOP_CODE_W-1:0];
      end else begin
        case (cfg_addr[2:0])
          3'd0: begin
            // a run always has between one and MAX_HOPS hops.
            if (cfg_wdata == '0) begin
              cfg.num_hops <= hop_num_t'(1);
            end else if (cfg_wdata > 16'(`MAX_HOPS)) begin
              cfg.num_hops <= hop_num_t'(`MAX_HOPS);
            end else begin
              cfg.num_hops <= hop_num_t'(cfg_wdata);
            end
          end
          3'd1: cfg.sync_len <= count_t'(cfg_wdata);
          3'd2: cfg.base_inc <= phase_t'(cfg_wdata);
          3'd3: cfg.hop_step <= phase_t'(cfg_wdata);
          default: ;
        endcase
      end
    end
  end

  assign code = code_tbl[hop_idx];

endmodule

`default_nettype wire

/* src/hop_tx_pkg.sv */
`default_nettype none

`include "hop_tx_params.svh"

package hop_tx_pkg;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;
  typedef logic [`PHASE_W-1:0] phase_t;
  typedef logic [`HOP_CODE_W-1:0] hop_code_t;
  typedef logic [`HOP_IDX_W-1:0] hop_idx_t;
  typedef logic [`HOP_IDX_W:0] hop_num_t;
  typedef logic [`COUNT_W-1:0] count_t;

  typedef struct packed {
    hop_num_t num_hops;
    count_t   sync_len;
    phase_t   base_inc;
    phase_t   hop_step;
  } hop_cfg_t;

  // strobes towards the tag chip scan chain.
  typedef struct packed {
    logic scan_id;
    logic phi;
    logic phi_bar;
    logic data;
    logic load;
  } scan_pins_t;

  typedef enum logic [1:0] {
    INIT,
    LOC_SYNC,
    HOP_SYNC,
    HOP_TX
  } seq_state_t;

endpackage

`default_nettype wire

/* src/hop_tx_params.svh */
`ifndef HOP_TX_PARAMS_SVH
`define HOP_TX_PARAMS_SVH

`define HOP_CODE_W 8
`define MAX_HOPS 8
`define HOP_IDX_W 3
`define SCAN_DIV 4
`define SAMPLE_W 12
`define PHASE_W 16
`define COUNT_W 16
`define GPIO_W 12

// front panel pin positions.
`define PIN_SYNC 0
`define PIN_EN_IN 1
`define PIN_LOAD 2
`define PIN_DATA 4
`define PIN_PHI_BAR 6
`define PIN_PHI 8
`define PIN_SCAN_ID 10
`define PIN_TX 11

// every pin above except PIN_EN_IN is an output.
`define GPIO_DDR_MASK 12'hd55

`endif
